// File: verilog/nocPkg.sv
`default_nettype none

package nocPkg;

  // Router ports. The index sets the bit order of req and grant.
  localparam int numPorts = 5;

  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  // One-hot arbiter state: bit 0 is idle, bits 1 to numPorts follow the port indices.
  typedef logic [numPorts:0] arbState;

  localparam arbState stateIdle = arbState'(1);
  localparam arbState stateL = arbState'(1) << (portL + 1);
  localparam arbState stateN = arbState'(1) << (portN + 1);
  localparam arbState stateE = arbState'(1) << (portE + 1);
  localparam arbState stateW = arbState'(1) << (portW + 1);
  localparam arbState stateS = arbState'(1) << (portS + 1);

endpackage

`default_nettype wire

// File: verilog/flitPkg.sv
`default_nettype none

package flitPkg;

  localparam int flitIdWidth = 3;
  localparam int payloadWidth = 16;
  localparam int headerLengthWidth = 12;
  localparam int destWidth = payloadWidth - headerLengthWidth;

  localparam logic [flitIdWidth-1:0] flitIdle = 3'b000;
  localparam logic [flitIdWidth-1:0] flitHeader = 3'b001;
  localparam logic [flitIdWidth-1:0] flitBody = 3'b010;
  localparam logic [flitIdWidth-1:0] flitTail = 3'b100;

  // Header view of the payload word.
  typedef struct packed {
    logic [headerLengthWidth-1:0] length;
    logic [destWidth-1:0] dest;
  } headerFields;

  // Body and tail flits carry plain data in the same word.
  typedef union packed {
    headerFields header;
    logic [payloadWidth-1:0] data;
  } flitPayload;

endpackage

`default_nettype wire

// File: verilog/inputStage.sv
`timescale 1ns/1ps
`default_nettype none

module inputStage
#(
  parameter int LengthWidth = 12
)
(
  input  logic clk,
  input  logic rst,
  input  logic [flitPkg::flitIdWidth-1:0] inFlitId,
  input  flitPkg::flitPayload inPayload,
  output logic [flitPkg::flitIdWidth-1:0] flitId,
  output flitPkg::flitPayload payload,
  output logic req,
  output logic [LengthWidth-1:0] length
);

  import flitPkg::*;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitId <= flitIdle;
      payload <= '0;
    end
    else
    begin
      flitId <= inFlitId;
      payload <= inPayload;
    end
  end

  assign req = (flitId != flitIdle); // Any flit kind other than idle asks for the output.

  // Only meaningful while a header sits in the register; the timer latches it then.
  assign length = LengthWidth'(payload.header.length);

endmodule

`default_nettype wire

// File: verilog/holdTimer.sv
`timescale 1ns/1ps
`default_nettype none

module holdTimer
#(
  parameter int LengthWidth = 12
)
(
  input  logic clk,
  input  logic rst,
  input  logic [flitPkg::flitIdWidth-1:0] flitId,
  input  logic [LengthWidth-1:0] length,
  input  logic runTimer,
  output logic timesUp
);

  import flitPkg::*;

  logic [LengthWidth-1:0] timeout;
  logic [LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      timeout <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == flitHeader)
      begin
        timeout <= length; // Each new header replaces the packet length.
      end
      count <= runTimer ? count + 1'b1 : '0;
    end
  end

  assign timesUp = (count == timeout);

endmodule

`default_nettype wire

// File: verilog/portArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module portArbiter
#(
  parameter int LengthWidth = 12
)
(
  input  logic clk,
  input  logic rst,
  input  logic [flitPkg::flitIdWidth-1:0] flitId [nocPkg::numPorts],
  input  logic [LengthWidth-1:0] length [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] req,
  output logic [nocPkg::numPorts-1:0] grant
);

  import nocPkg::*;

  arbState state;
  arbState nextState;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;
  logic holding;
  int heldPort;

  // Index of the port that follows base by offset steps in rotation order.
  function automatic int rotateIndex(input int base, input int offset);
    int idx;
    idx = base + offset;
    if (idx >= numPorts)
    begin
      idx = idx - numPorts;
    end
    return idx;
  endfunction

  generate
    for (genvar p = 0; p < numPorts; p++)
    begin : gTimer
      holdTimer #(
        .LengthWidth(LengthWidth)
      ) i_holdTimer (
        .clk(clk),
        .rst(rst),
        .flitId(flitId[p]),
        .length(length[p]),
        .runTimer(runTimer[p]),
        .timesUp(timesUp[p])
      );
    end
  endgenerate

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stateIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    holding = 1'b1;
    heldPort = portL;
    case (state)
      stateL: heldPort = portL;
      stateN: heldPort = portN;
      stateE: heldPort = portE;
      stateW: heldPort = portW;
      stateS: heldPort = portS;
      default: holding = 1'b0; // Idle, or a broken encoding that falls back to idle rules.
    endcase
  end

  always_comb
  begin
    nextState = stateIdle;
    runTimer = '0;
    if (!holding)
    begin
      // Scan downwards so the lowest requesting index wins, giving L, N, E, W, S priority.
      for (int k = numPorts - 1; k >= 0; k--)
      begin
        if (req[k])
        begin
          nextState = arbState'(1) << (k + 1);
        end
      end
    end
    else if (req[heldPort] && !timesUp[heldPort])
    begin
      nextState = state;
      runTimer[heldPort] = 1'b1; // The count runs only while the port is kept.
    end
    else
    begin
      // The releasing port is skipped, so it goes idle if nobody else asks.
      for (int k = numPorts - 1; k > 0; k--)
      begin
        if (req[rotateIndex(heldPort, k)])
        begin
          nextState = arbState'(1) << (rotateIndex(heldPort, k) + 1);
        end
      end
    end
  end

  assign grant = state[numPorts:1];

endmodule

`default_nettype wire

// File: verilog/outputSelect.sv
`timescale 1ns/1ps
`default_nettype none

module outputSelect
(
  input  logic [nocPkg::numPorts-1:0] grant,
  input  logic [flitPkg::flitIdWidth-1:0] flitId [nocPkg::numPorts],
  input  flitPkg::flitPayload payload [nocPkg::numPorts],
  output logic [flitPkg::flitIdWidth-1:0] outFlitId,
  output flitPkg::flitPayload outPayload,
  output logic outValid
);

  import nocPkg::*;
  import flitPkg::*;

  // The grant is one-hot, so an AND-OR mux picks exactly one port or none.
  always_comb
  begin
    outFlitId = '0;
    outPayload = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      outFlitId = outFlitId | (flitId[p] & {flitIdWidth{grant[p]}});
      outPayload.data = outPayload.data | (payload[p].data & {payloadWidth{grant[p]}});
    end
  end

  assign outValid = |grant;

endmodule

`default_nettype wire

// File: verilog/routerOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
#(
  parameter int LengthWidth = 12
)
(
  input  logic clk,
  input  logic rst,
  input  logic [flitPkg::flitIdWidth-1:0] inFlitIdL,
  input  logic [flitPkg::flitIdWidth-1:0] inFlitIdN,
  input  logic [flitPkg::flitIdWidth-1:0] inFlitIdE,
  input  logic [flitPkg::flitIdWidth-1:0] inFlitIdW,
  input  logic [flitPkg::flitIdWidth-1:0] inFlitIdS,
  input  flitPkg::flitPayload inPayloadL,
  input  flitPkg::flitPayload inPayloadN,
  input  flitPkg::flitPayload inPayloadE,
  input  flitPkg::flitPayload inPayloadW,
  input  flitPkg::flitPayload inPayloadS,
  output logic [nocPkg::numPorts-1:0] grant,
  output logic [flitPkg::flitIdWidth-1:0] outFlitId,
  output flitPkg::flitPayload outPayload,
  output logic outValid
);

  import nocPkg::*;
  import flitPkg::*;

  logic [flitIdWidth-1:0] rawFlitId [numPorts];
  flitPayload rawPayload [numPorts];
  logic [flitIdWidth-1:0] stageFlitId [numPorts];
  flitPayload stagePayload [numPorts];
  logic [numPorts-1:0] stageReq;
  logic [LengthWidth-1:0] stageLength [numPorts];

  // Gather the named ports into arrays in port index order.
  assign rawFlitId[portL] = inFlitIdL;
  assign rawFlitId[portN] = inFlitIdN;
  assign rawFlitId[portE] = inFlitIdE;
  assign rawFlitId[portW] = inFlitIdW;
  assign rawFlitId[portS] = inFlitIdS;

  assign rawPayload[portL] = inPayloadL;
  assign rawPayload[portN] = inPayloadN;
  assign rawPayload[portE] = inPayloadE;
  assign rawPayload[portW] = inPayloadW;
  assign rawPayload[portS] = inPayloadS;

  generate
    for (genvar p = 0; p < numPorts; p++)
    begin : gStage
      inputStage #(
        .LengthWidth(LengthWidth)
      ) i_inputStage (
        .clk(clk),
        .rst(rst),
        .inFlitId(rawFlitId[p]),
        .inPayload(rawPayload[p]),
        .flitId(stageFlitId[p]),
        .payload(stagePayload[p]),
        .req(stageReq[p]),
        .length(stageLength[p])
      );
    end
  endgenerate

  portArbiter #(
    .LengthWidth(LengthWidth)
  ) i_portArbiter (
    .clk(clk),
    .rst(rst),
    .flitId(stageFlitId),
    .length(stageLength),
    .req(stageReq),
    .grant(grant)
  );

  // Output follows grant in the same cycle, straight from the stage registers.
  outputSelect i_outputSelect (
    .grant(grant),
    .flitId(stageFlitId),
    .payload(stagePayload),
    .outFlitId(outFlitId),
    .outPayload(outPayload),
    .outValid(outValid)
  );

endmodule

`default_nettype wire

// File: verification/routerOutputPortTb.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPortTb;

  import nocPkg::*;
  import flitPkg::*;

  localparam int clockPeriod = 100;
  localparam int fieldsPerVector = 14;
  localparam int maxVectors = 64;
  localparam int resetTimeout = 10;
  localparam int watchdogCycles = 1000;
  localparam logic [15:0] endMarker = 16'hffff;

  logic clk;
  logic rst;
  logic [flitIdWidth-1:0] inFlitIdL;
  logic [flitIdWidth-1:0] inFlitIdN;
  logic [flitIdWidth-1:0] inFlitIdE;
  logic [flitIdWidth-1:0] inFlitIdW;
  logic [flitIdWidth-1:0] inFlitIdS;
  flitPayload inPayloadL;
  flitPayload inPayloadN;
  flitPayload inPayloadE;
  flitPayload inPayloadW;
  flitPayload inPayloadS;
  logic [numPorts-1:0] grant;
  logic [flitIdWidth-1:0] outFlitId;
  flitPayload outPayload;
  logic outValid;

  // Each vector is 14 words: test, five ids, five payloads, grant, flit id, payload.
  logic [15:0] vectors [maxVectors * fieldsPerVector];
  int numVectors;
  logic dataOk;
  int errorCount;
  int checkCount;
  int testErrors;
  int testChecks;
  int testsDone;

  routerOutputPort #(
    .LengthWidth(12)
  ) i_routerOutputPort (
    .clk(clk),
    .rst(rst),
    .inFlitIdL(inFlitIdL),
    .inFlitIdN(inFlitIdN),
    .inFlitIdE(inFlitIdE),
    .inFlitIdW(inFlitIdW),
    .inFlitIdS(inFlitIdS),
    .inPayloadL(inPayloadL),
    .inPayloadN(inPayloadN),
    .inPayloadE(inPayloadE),
    .inPayloadW(inPayloadW),
    .inPayloadS(inPayloadS),
    .grant(grant),
    .outFlitId(outFlitId),
    .outPayload(outPayload),
    .outValid(outValid)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #(clockPeriod / 2) clk = ~clk;

  initial
  begin
    #(watchdogCycles * clockPeriod);
    $display("Simulation did not finish within %0d clock cycles.", watchdogCycles);
    $display("TEST FAIL");
    $finish;
  end

  function automatic logic [15:0] vectorField(input int v, input int f);
    return vectors[v * fieldsPerVector + f];
  endfunction

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    checkCount++;
    testChecks++;
    if (actual !== expected)
    begin
      errorCount++;
      testErrors++;
      $display("CHECK FAILED at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic finishTest(input int testId);
    $display("Test %0d finished: %0d checks, %0d errors", testId, testChecks, testErrors);
    testsDone++;
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic loadVectors;
    int v;
    logic stop;
    logic complete;
    $readmemh("verification/routerOutputPort_tests.txt", vectors);
    v = 0;
    stop = 1'b0;
    complete = 1'b1;
    while (!stop && v < maxVectors)
    begin
      if (vectorField(v, 0) === endMarker)
      begin
        stop = 1'b1;
      end
      else
      begin
        for (int f = 0; f < fieldsPerVector; f++)
        begin
          if ($isunknown(vectorField(v, f)))
          begin
            complete = 1'b0;
          end
        end
        if (complete)
        begin
          v++;
        end
        else
        begin
          stop = 1'b1;
        end
      end
    end
    numVectors = v;
    dataOk = complete && (v > 0) && (vectorField(v, 0) === endMarker);
    if ($isunknown(vectorField(0, 0)))
    begin
      $display("No stimulus could be read; the data file is missing or empty.");
    end
    else if (!dataOk)
    begin
      $display("The data file is short: vector %0d is incomplete or the end marker is missing.", v);
    end
  endtask

  task automatic applyVector(input int v);
    inFlitIdL <= flitIdWidth'(vectorField(v, 1));
    inFlitIdN <= flitIdWidth'(vectorField(v, 2));
    inFlitIdE <= flitIdWidth'(vectorField(v, 3));
    inFlitIdW <= flitIdWidth'(vectorField(v, 4));
    inFlitIdS <= flitIdWidth'(vectorField(v, 5));
    inPayloadL.data <= vectorField(v, 6);
    inPayloadN.data <= vectorField(v, 7);
    inPayloadE.data <= vectorField(v, 8);
    inPayloadW.data <= vectorField(v, 9);
    inPayloadS.data <= vectorField(v, 10);
  endtask

  task automatic checkVector(input int v);
    compareValue("grant", grant, vectorField(v, 11));
    compareValue("outValid", outValid, vectorField(v, 11) != 16'h0); // Valid whenever a port is granted.
    compareValue("outFlitId", outFlitId, vectorField(v, 12));
    compareValue("outPayload", outPayload.data, vectorField(v, 13));
    if (vectorField(v + 1, 0) !== vectorField(v, 0))
    begin
      finishTest(vectorField(v, 0));
    end
  endtask

  task automatic waitResetRelease;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rst !== 1'b0 && cycles < resetTimeout)
    begin
      @(negedge clk);
      cycles++;
    end
    if (rst !== 1'b0)
    begin
      $display("Reset was still asserted after %0d cycles.", resetTimeout);
      errorCount++;
    end
  endtask

  // A row is sampled one edge after it is driven, so it is checked one cycle later.
  task automatic runVectors;
    for (int v = 0; v < numVectors; v++)
    begin
      @(posedge clk);
      applyVector(v);
      @(negedge clk);
      if (v > 0)
      begin
        checkVector(v - 1);
      end
    end
    @(posedge clk);
    applyVector(numVectors); // The end marker row drives idle flits.
    @(negedge clk);
    checkVector(numVectors - 1);
  endtask

  initial
  begin
    rst = 1'b1;
    inFlitIdL = flitIdle;
    inFlitIdN = flitIdle;
    inFlitIdE = flitIdle;
    inFlitIdW = flitIdle;
    inFlitIdS = flitIdle;
    inPayloadL = '0;
    inPayloadN = '0;
    inPayloadE = '0;
    inPayloadW = '0;
    inPayloadS = '0;
    errorCount = 0;
    checkCount = 0;
    testErrors = 0;
    testChecks = 0;
    testsDone = 0;
    loadVectors();
    if (dataOk)
    begin
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      waitResetRelease();
      compareValue("grant", grant, 0);
      compareValue("outValid", outValid, 0);
      finishTest(0);
      runVectors();
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", testsDone, checkCount, errorCount);
    if (dataOk && errorCount == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/routerOutputPort_tests.txt
// test idL idN idE idW idS payL payN payE payW payS grant outFlitId outPayload (hex)
// Expected values hold while the stage registers carry the row; ffff marks the end.
1 0 0 0 0 0 0000 0000 0000 0000 0000 00 0 0000
1 0 0 0 0 0 0000 0000 0000 0000 0000 00 0 0000
2 1 1 1 1 1 0001 0002 0003 0004 0005 00 0 0000
2 4 2 2 2 2 1003 2003 3003 4003 5003 01 4 1003
2 0 4 2 2 2 0000 2004 3004 4004 5004 02 4 2004
2 0 0 4 2 2 0000 0000 3005 4005 5005 04 4 3005
2 0 0 0 4 2 0000 0000 0000 4006 5006 08 4 4006
2 0 0 0 0 4 0000 0000 0000 0000 5007 10 4 5007
3 0 0 1 0 0 0000 0000 0003 0000 0000 00 0 0000
3 0 0 4 0 0 0000 0000 3009 0000 0000 04 4 3009
3 0 0 0 0 0 0000 0000 0000 0000 0000 00 0 0000
4 0 1 0 1 0 0000 0052 0000 0024 0000 00 0 0000
4 0 2 0 2 0 0000 200c 0000 400c 0000 02 2 200c
4 0 2 0 2 0 0000 200d 0000 400d 0000 02 2 200d
4 0 2 0 2 0 0000 200e 0000 400e 0000 02 2 200e
4 0 2 0 2 0 0000 200f 0000 400f 0000 02 2 200f
4 0 2 0 2 0 0000 2010 0000 4010 0000 02 2 2010
4 0 4 0 2 0 0000 2011 0000 4011 0000 02 4 2011
4 0 0 0 2 0 0000 0000 0000 4012 0000 08 2 4012
4 0 0 0 2 1 0000 0000 0000 4013 0005 08 2 4013
4 0 0 0 4 2 0000 0000 0000 4014 5014 08 4 4014
4 0 0 0 0 4 0000 0000 0000 0000 5015 10 4 5015
5 1 1 1 1 1 0011 0002 0023 0004 0015 00 0 0000
5 2 2 2 2 2 1017 2017 3017 4017 5017 01 2 1017
5 2 2 2 2 2 1018 2018 3018 4018 5018 01 2 1018
5 2 2 2 2 2 1019 2019 3019 4019 5019 02 2 2019
5 2 2 2 2 2 101a 201a 301a 401a 501a 04 2 301a
5 2 2 2 2 2 101b 201b 301b 401b 501b 04 2 301b
5 2 2 2 2 2 101c 201c 301c 401c 501c 04 2 301c
5 2 2 2 2 2 101d 201d 301d 401d 501d 08 2 401d
5 2 2 2 2 2 101e 201e 301e 401e 501e 10 2 501e
5 2 2 2 2 2 101f 201f 301f 401f 501f 10 2 501f
6 0 2 2 2 2 0000 2020 3020 4020 5020 01 0 0000
6 0 4 0 0 0 0000 2021 0000 0000 0000 02 4 2021
6 0 0 0 0 0 0000 0000 0000 0000 0000 00 0 0000
ffff 0 0 0 0 0 0000 0000 0000 0000 0000 00 0 0000

// File: project.f
verilog/nocPkg.sv
verilog/flitPkg.sv
verilog/inputStage.sv
verilog/holdTimer.sv
verilog/portArbiter.sv
verilog/outputSelect.sv
verilog/routerOutputPort.sv
verification/routerOutputPortTb.sv
